//--- verilog/axiBridgePkg.sv
package axiBridgePkg;

    // bus geometry
    localparam int wordW = 32;
    localparam int addrW = 32;
    localparam int strbW = wordW / 8;
    localparam int lineBeats = 4;
    localparam int lineW = wordW * lineBeats;
    localparam int beatCntW = $clog2(lineBeats);
    localparam int lineOffsetBits = 4;

    // AXI field widths
    localparam int idW = 4;
    localparam int lenW = 4;
    localparam int sizeW = 3;
    localparam int burstW = 2;

    localparam logic [idW-1:0] idInst = 4'd0;
    localparam logic [idW-1:0] idData = 4'd1;

    localparam logic [lenW-1:0] lineLen = 4'd3;     // four beats per line
    localparam logic [lenW-1:0] singleLen = 4'd0;

    localparam logic [sizeW-1:0] wordSize = 3'd2;   // four bytes per beat

    localparam logic [burstW-1:0] burstFixed = 2'd0;
    localparam logic [burstW-1:0] burstIncr = 2'd1;
    localparam logic [burstW-1:0] burstWrap = 2'd2;

    typedef logic [wordW-1:0] wordT;
    typedef logic [lineW-1:0] lineT;

    typedef struct packed {
        logic [addrW-1:0] pc;
    } instReqT;

    typedef struct packed {
        logic [addrW-1:0] addr;
        wordT             data;
        logic             writeEn;
        logic [strbW-1:0] strobe;
        logic [sizeW-1:0] size;
    } dataReqT;

    typedef struct packed {
        logic [idW-1:0]    id;
        logic [addrW-1:0]  addr;
        logic [lenW-1:0]   len;
        logic [sizeW-1:0]  size;
        logic [burstW-1:0] burst;
    } axiAddrT;

    typedef struct packed {
        wordT             data;
        logic [strbW-1:0] strobe;
        logic             last;
    } axiWDataT;

    typedef struct packed {
        logic [idW-1:0] id;
        wordT           data;
        logic           last;
    } axiRDataT;

endpackage

//--- verilog/axiReqCapture.sv
`timescale 1ns/1ps

module axiReqCapture (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instReqValid,
    input  axiBridgePkg::instReqT  instReq,
    input  logic                   dataReqValid,
    input  axiBridgePkg::dataReqT  dataReq,
    input  logic                   instDone,
    input  logic                   dataDone,
    output logic                   instReqReady,
    output logic                   dataReqReady,
    output logic                   instPending,
    output logic                   dataReadPending,
    output logic                   dataWritePending,
    output axiBridgePkg::axiAddrT  rdAddr,
    output axiBridgePkg::axiAddrT  wrAddr,
    output axiBridgePkg::axiWDataT wrBeat
);

    logic                  instBusy;
    logic                  dataBusy;
    axiBridgePkg::instReqT instSlot;
    axiBridgePkg::dataReqT dataSlot;
    logic                  instLoad;
    logic                  dataLoad;

    assign instReqReady = !instBusy;
    assign dataReqReady = !dataBusy;
    assign instLoad = instReqValid && instReqReady;
    assign dataLoad = dataReqValid && dataReqReady;

    assign instPending = instBusy;
    assign dataReadPending = dataBusy && !dataSlot.writeEn;
    assign dataWritePending = dataBusy && dataSlot.writeEn;

    always_ff @(posedge clk) begin
        if (rst) begin
            instBusy <= 1'b0;
            dataBusy <= 1'b0;
        end else begin
            if (instLoad) begin
                instBusy <= 1'b1;
            end else if (instDone) begin
                instBusy <= 1'b0;    // freed once the fetch address is on its way
            end
            if (dataLoad) begin
                dataBusy <= 1'b1;
            end else if (dataDone) begin
                dataBusy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instLoad) begin
            instSlot <= instReq;
        end
        if (dataLoad) begin
            dataSlot <= dataReq;
        end
    end

    // a waiting data read wins the read address channel over a fetch
    always_comb begin
        if (dataReadPending) begin
            rdAddr.id = axiBridgePkg::idData;
            rdAddr.addr = dataSlot.addr;
            rdAddr.len = axiBridgePkg::singleLen;
            rdAddr.size = dataSlot.size;
            rdAddr.burst = axiBridgePkg::burstFixed;
        end else begin
            rdAddr.id = axiBridgePkg::idInst;
            rdAddr.addr = {instSlot.pc[axiBridgePkg::addrW-1:axiBridgePkg::lineOffsetBits],
                           {axiBridgePkg::lineOffsetBits{1'b0}}};
            rdAddr.len = axiBridgePkg::lineLen;
            rdAddr.size = axiBridgePkg::wordSize;
            rdAddr.burst = axiBridgePkg::burstWrap;
        end
    end

    always_comb begin
        wrAddr.id = axiBridgePkg::idData;
        wrAddr.addr = dataSlot.addr;
        wrAddr.len = axiBridgePkg::singleLen;
        wrAddr.size = dataSlot.size;
        wrAddr.burst = axiBridgePkg::burstIncr;
        wrBeat.data = dataSlot.data;
        wrBeat.strobe = dataSlot.strobe;
        wrBeat.last = 1'b1;      // single beat write
    end

    // a done pulse always belongs to a request held in its slot
    assert property (@(posedge clk) disable iff (rst) instDone |-> instBusy)
        else $error("instruction done pulse with an empty slot");

    assert property (@(posedge clk) disable iff (rst) dataDone |-> dataBusy)
        else $error("data done pulse with an empty slot");

endmodule

//--- verilog/axiReadEngine.sv
`timescale 1ns/1ps

module axiReadEngine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instPending,
    input  logic                   dataReadPending,
    input  axiBridgePkg::axiAddrT  rdAddr,
    input  logic                   arReady,
    input  logic                   rValid,
    input  axiBridgePkg::axiRDataT r,
    input  logic                   instRespReady,
    input  logic                   dataRespReady,
    output logic                   arValid,
    output axiBridgePkg::axiAddrT  ar,
    output logic                   rReady,
    output logic                   instRespValid,
    output axiBridgePkg::lineT     instLine,
    output logic                   dataRespValid,
    output axiBridgePkg::wordT     dataRdata,
    output logic                   instDone,
    output logic                   dataDone
);

    typedef enum logic [1:0] {
        idle,
        instBeats,
        dataBeat
    } stateT;

    stateT                             state;
    logic [axiBridgePkg::beatCntW-1:0] beatCnt;
    axiBridgePkg::lineT                lineBuf;
    logic                              arHeld;
    axiBridgePkg::axiAddrT             arHold;
    logic                              arFire;
    logic                              arIsData;
    logic                              rFire;

    assign arValid = (state == idle) && (instPending || dataReadPending);
    assign ar = arHeld ? arHold : rdAddr;   // an offered phase stays put until it is taken
    assign arFire = arValid && arReady;
    assign arIsData = (ar.id == axiBridgePkg::idData);
    assign rFire = rValid && rReady;

    assign instDone = arFire && !arIsData;
    assign dataDone = (state == dataBeat) && rFire;
    assign dataRdata = r.data;

    always_comb begin
        rReady = 1'b0;
        instRespValid = 1'b0;
        dataRespValid = 1'b0;
        case (state)
            instBeats: begin
                instRespValid = rValid && r.last;
                rReady = !(rValid && r.last) || instRespReady;  // last beat waits on the CPU
            end
            dataBeat: begin
                dataRespValid = rValid;
                rReady = dataRespReady;
            end
            default: begin
                rReady = 1'b0;
            end
        endcase
    end

    // the beat on the bus fills the slot the counter points at
    always_comb begin
        instLine = lineBuf;
        instLine[beatCnt*axiBridgePkg::wordW +: axiBridgePkg::wordW] = r.data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            beatCnt <= '0;
            arHeld <= 1'b0;
        end else begin
            arHeld <= arValid && !arReady;
            case (state)
                idle: begin
                    if (arFire) begin
                        state <= arIsData ? dataBeat : instBeats;
                    end
                end
                instBeats: begin
                    if (rFire) begin
                        beatCnt <= r.last ? '0 : beatCnt + 1'b1;
                        if (r.last) begin
                            state <= idle;
                        end
                    end
                end
                dataBeat: begin
                    if (rFire) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!arHeld) begin
            arHold <= rdAddr;
        end
        if (state == instBeats && rFire) begin
            lineBuf[beatCnt*axiBridgePkg::wordW +: axiBridgePkg::wordW] <= r.data;
        end
    end

    // a read beat only comes back for an address the engine has handed over
    assert property (@(posedge clk) disable iff (rst) state == idle |-> !rValid)
        else $error("read beat offered while no burst is outstanding");

    // the slave must close a line burst on exactly the fourth beat
    assert property (@(posedge clk) disable iff (rst)
        state == instBeats && rFire && r.last |-> beatCnt == axiBridgePkg::lineBeats - 1)
        else $error("line burst ended on beat %0d", beatCnt);

endmodule

//--- verilog/axiWriteEngine.sv
`timescale 1ns/1ps

module axiWriteEngine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dataWritePending,
    input  axiBridgePkg::axiAddrT  wrAddr,
    input  axiBridgePkg::axiWDataT wrBeat,
    input  logic                   awReady,
    input  logic                   wReady,
    input  logic                   bValid,
    output logic                   awValid,
    output axiBridgePkg::axiAddrT  aw,
    output logic                   wValid,
    output axiBridgePkg::axiWDataT w,
    output logic                   bReady,
    output logic                   writeDone
);

    typedef enum logic [1:0] {
        idle,
        addr,
        data,
        resp
    } stateT;

    stateT state;

    // the capture slot holds the write steady until writeDone
    assign aw = wrAddr;
    assign w = wrBeat;

    assign awValid = (state == addr);
    assign wValid = (state == data);
    assign bReady = (state == resp);
    assign writeDone = bReady && bValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (dataWritePending) begin
                        state <= addr;
                    end
                end
                addr: begin
                    if (awReady) begin
                        state <= data;
                    end
                end
                data: begin
                    if (wReady) begin
                        state <= resp;
                    end
                end
                resp: begin
                    if (bValid) begin
                        state <= idle;   // slot is released on the same edge
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // a write response only comes back once the write beat has gone out
    assert property (@(posedge clk) disable iff (rst) bValid |-> bReady)
        else $error("bValid raised with no write response owed");

    assert property (@(posedge clk) disable iff (rst)
        writeDone |-> $past(dataWritePending))
        else $error("write response with no write pending");

endmodule

//--- verilog/axiBridge.sv
`timescale 1ns/1ps

module axiBridge (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instReqValid,
    input  axiBridgePkg::instReqT  instReq,
    output logic                   instReqReady,
    output logic                   instRespValid,
    output axiBridgePkg::lineT     instLine,
    input  logic                   instRespReady,
    input  logic                   dataReqValid,
    input  axiBridgePkg::dataReqT  dataReq,
    output logic                   dataReqReady,
    output logic                   dataRespValid,
    output axiBridgePkg::wordT     dataRdata,
    input  logic                   dataRespReady,
    output logic                   arValid,
    output axiBridgePkg::axiAddrT  ar,
    input  logic                   arReady,
    input  logic                   rValid,
    input  axiBridgePkg::axiRDataT r,
    output logic                   rReady,
    output logic                   awValid,
    output axiBridgePkg::axiAddrT  aw,
    input  logic                   awReady,
    output logic                   wValid,
    output axiBridgePkg::axiWDataT w,
    input  logic                   wReady,
    input  logic                   bValid,
    output logic                   bReady
);

    logic                   instPending;
    logic                   dataReadPending;
    logic                   dataWritePending;
    axiBridgePkg::axiAddrT  rdAddr;
    axiBridgePkg::axiAddrT  wrAddr;
    axiBridgePkg::axiWDataT wrBeat;
    logic                   instDone;
    logic                   readDataDone;
    logic                   writeDone;

    axiReqCapture reqCapture (
        .clk(clk),
        .rst(rst),
        .instReqValid(instReqValid),
        .instReq(instReq),
        .dataReqValid(dataReqValid),
        .dataReq(dataReq),
        .instDone(instDone),
        .dataDone(readDataDone | writeDone),   // either engine frees the data slot
        .instReqReady(instReqReady),
        .dataReqReady(dataReqReady),
        .instPending(instPending),
        .dataReadPending(dataReadPending),
        .dataWritePending(dataWritePending),
        .rdAddr(rdAddr),
        .wrAddr(wrAddr),
        .wrBeat(wrBeat)
    );

    axiReadEngine readEngine (
        .clk(clk),
        .rst(rst),
        .instPending(instPending),
        .dataReadPending(dataReadPending),
        .rdAddr(rdAddr),
        .arReady(arReady),
        .rValid(rValid),
        .r(r),
        .instRespReady(instRespReady),
        .dataRespReady(dataRespReady),
        .arValid(arValid),
        .ar(ar),
        .rReady(rReady),
        .instRespValid(instRespValid),
        .instLine(instLine),
        .dataRespValid(dataRespValid),
        .dataRdata(dataRdata),
        .instDone(instDone),
        .dataDone(readDataDone)
    );

    axiWriteEngine writeEngine (
        .clk(clk),
        .rst(rst),
        .dataWritePending(dataWritePending),
        .wrAddr(wrAddr),
        .wrBeat(wrBeat),
        .awReady(awReady),
        .wReady(wReady),
        .bValid(bValid),
        .awValid(awValid),
        .aw(aw),
        .wValid(wValid),
        .w(w),
        .bReady(bReady),
        .writeDone(writeDone)
    );

endmodule

//--- verif/axiBridgeTb.sv
`timescale 1ns/1ps

module axiBridgeTb;

    localparam int numReqs = 300;
    localparam int runLimit = 100000;
    localparam logic [31:0] windowBase = 32'h0000_1000;   // 64 words shared by fetches and data

    logic                   clk;
    logic                   rst;
    logic                   instReqValid;
    axiBridgePkg::instReqT  instReq;
    logic                   instReqReady;
    logic                   instRespValid;
    axiBridgePkg::lineT     instLine;
    logic                   instRespReady;
    logic                   dataReqValid;
    axiBridgePkg::dataReqT  dataReq;
    logic                   dataReqReady;
    logic                   dataRespValid;
    axiBridgePkg::wordT     dataRdata;
    logic                   dataRespReady;
    logic                   arValid;
    axiBridgePkg::axiAddrT  ar;
    logic                   arReady;
    logic                   rValid;
    axiBridgePkg::axiRDataT r;
    logic                   rReady;
    logic                   awValid;
    axiBridgePkg::axiAddrT  aw;
    logic                   awReady;
    logic                   wValid;
    axiBridgePkg::axiWDataT w;
    logic                   wReady;
    logic                   bValid;
    logic                   bReady;

    axiBridgePkg::wordT     slaveMem [logic [29:0]];
    axiBridgePkg::wordT     modelMem [logic [29:0]];
    axiBridgePkg::instReqT  instQ[$];     // accepted fetches whose AR is still to come
    axiBridgePkg::dataReqT  dataQ[$];
    axiBridgePkg::lineT     lineExpQ[$];
    axiBridgePkg::wordT     wordExpQ[$];
    axiBridgePkg::axiRDataT beatQ[$];
    axiBridgePkg::axiAddrT  awSeen;
    axiBridgePkg::axiAddrT  arPrev;
    axiBridgePkg::axiWDataT wSeen;
    logic                   bOwed;
    logic                   arWaitPrev;
    int                     issued;
    int                     fetchCnt;
    int                     readCnt;
    int                     writeCnt;
    int                     arbCnt;
    int                     mismatchCnt;
    int                     protocolCnt;
    int                     timeoutCnt;
    int                     cycles;
    int                     seed;

    axiBridge dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // unwritten memory reads back a pattern of the full byte address
    function automatic axiBridgePkg::wordT fillWord(logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    function automatic axiBridgePkg::wordT slaveRead(logic [31:0] addr);
        if (slaveMem.exists(addr[31:2]))
            return slaveMem[addr[31:2]];
        return fillWord({addr[31:2], 2'b00});
    endfunction

    function automatic axiBridgePkg::wordT modelRead(logic [31:0] addr);
        if (modelMem.exists(addr[31:2]))
            return modelMem[addr[31:2]];
        return fillWord({addr[31:2], 2'b00});
    endfunction

    function automatic axiBridgePkg::wordT mergeBytes(axiBridgePkg::wordT old,
                                                      axiBridgePkg::wordT data, logic [3:0] strobe);
        axiBridgePkg::wordT res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strobe[i])
                res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    function automatic axiBridgePkg::lineT modelLine(logic [31:0] pc);
        axiBridgePkg::lineT line;
        for (int i = 0; i < 4; i++)
            line[32*i +: 32] = modelRead({pc[31:4], 4'b0000} + 32'(4 * i));   // low word first
        return line;
    endfunction

    function automatic axiBridgePkg::axiAddrT fetchAddr(logic [31:0] pc);
        axiBridgePkg::axiAddrT a;
        a.id = 4'd0;
        a.addr = {pc[31:4], 4'b0000};
        a.len = 4'd3;
        a.size = 3'd2;
        a.burst = 2'd2;   // wrap
        return a;
    endfunction

    function automatic axiBridgePkg::axiAddrT dataAddr(axiBridgePkg::dataReqT req, logic [1:0] burst);
        axiBridgePkg::axiAddrT a;
        a.id = 4'd1;
        a.addr = req.addr;
        a.len = 4'd0;
        a.size = req.size;
        a.burst = burst;
        return a;
    endfunction

    task automatic compareFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            mismatchCnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compareWord(string name, axiBridgePkg::wordT got, axiBridgePkg::wordT exp);
        if (got !== exp) begin
            mismatchCnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compareLine(string name, axiBridgePkg::lineT got, axiBridgePkg::lineT exp);
        if (got !== exp) begin
            mismatchCnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compareAddr(string name, axiBridgePkg::axiAddrT got, axiBridgePkg::axiAddrT exp);
        if (got !== exp) begin
            mismatchCnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compareBeat(string name, axiBridgePkg::axiWDataT got, axiBridgePkg::axiWDataT exp);
        if (got !== exp) begin
            mismatchCnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic reportProtocol(string what);
        protocolCnt++;
        $display("ERROR: %s", what);
    endtask

    task automatic queueBurst(axiBridgePkg::axiAddrT a);
        logic [31:0]            wrapBytes;
        logic [31:0]            base;
        logic [31:0]            beatAddr;
        axiBridgePkg::axiRDataT beat;
        wrapBytes = (32'(a.len) + 1) * 4;
        base = a.addr & ~(wrapBytes - 1);
        for (int k = 0; k <= int'(a.len); k++) begin
            case (a.burst)
                2'd0: beatAddr = a.addr;
                2'd2: beatAddr = base + ((a.addr - base + 32'(4 * k)) % wrapBytes);
                default: beatAddr = a.addr + 32'(4 * k);
            endcase
            beat.id = a.id;
            beat.data = slaveRead(beatAddr);   // the beat data is fixed when the address is taken
            beat.last = (k == int'(a.len));
            beatQ.push_back(beat);
        end
    endtask

    task automatic checkArChannel();
        axiBridgePkg::dataReqT dreq;
        axiBridgePkg::instReqT ireq;
        logic                  dataWaiting;
        dataWaiting = (dataQ.size() > 0) && !dataQ[0].writeEn;
        if (arWaitPrev) begin
            compareFlag("arValid", arValid, 1'b1);
            compareAddr("ar", ar, arPrev);
        end else if (arValid && dataWaiting && instQ.size() > 0) begin
            arbCnt++;
            compareAddr("ar", ar, dataAddr(dataQ[0], 2'd0));   // the data read goes ahead of the fetch
        end
        if (arValid && arReady) begin
            if (ar.id == 4'd1 && dataWaiting) begin
                dreq = dataQ.pop_front();
                compareAddr("ar", ar, dataAddr(dreq, 2'd0));
                wordExpQ.push_back(modelRead(dreq.addr));
            end else if (instQ.size() > 0) begin
                ireq = instQ.pop_front();
                compareAddr("ar", ar, fetchAddr(ireq.pc));
                lineExpQ.push_back(modelLine(ireq.pc));
            end else begin
                reportProtocol("read address handshake with no request waiting for it");
            end
            queueBurst(ar);
        end
        arWaitPrev = arValid && !arReady;
        arPrev = ar;
        arReady <= ($urandom % 3) == 0;
    endtask

    task automatic serveReadBeats();
        if (rValid && rReady && beatQ.size() > 0)
            beatQ.delete(0);
        if (!rValid || rReady) begin
            if (beatQ.size() > 0 && ($urandom % 4) != 0) begin
                rValid <= 1'b1;
                r <= beatQ[0];
            end else begin
                rValid <= 1'b0;
            end
        end
    endtask

    task automatic serveWrite();
        axiBridgePkg::dataReqT  dreq;
        axiBridgePkg::axiWDataT expBeat;
        logic                   writeWaiting;
        writeWaiting = (dataQ.size() > 0) && dataQ[0].writeEn;
        if (awValid && awReady) begin
            if (writeWaiting)
                compareAddr("aw", aw, dataAddr(dataQ[0], 2'd1));
            else
                reportProtocol("write address handshake with no write waiting");
            awSeen = aw;
        end
        if (wValid && wReady) begin
            if (writeWaiting) begin
                expBeat.data = dataQ[0].data;
                expBeat.strobe = dataQ[0].strobe;
                expBeat.last = 1'b1;
                compareBeat("w", w, expBeat);
                wSeen = w;
                bOwed = 1'b1;
            end else begin
                reportProtocol("write data handshake with no write waiting");
            end
        end
        if (bValid && bReady) begin
            slaveMem[awSeen.addr[31:2]] = mergeBytes(slaveRead(awSeen.addr), wSeen.data,
                                                     wSeen.strobe);
            if (writeWaiting) begin
                dreq = dataQ.pop_front();
                modelMem[dreq.addr[31:2]] = mergeBytes(modelRead(dreq.addr), dreq.data,
                                                       dreq.strobe);
                writeCnt++;
            end
            bValid <= 1'b0;
        end else if (!bValid && bOwed && ($urandom % 3) == 0) begin
            bValid <= 1'b1;
            bOwed = 1'b0;
        end
        awReady <= ($urandom % 3) == 0;
        wReady <= ($urandom % 3) == 0;
    endtask

    task automatic collectResponses();
        axiBridgePkg::lineT expLine;
        axiBridgePkg::wordT expWord;
        if (instRespValid && instRespReady) begin
            if (lineExpQ.size() > 0) begin
                expLine = lineExpQ.pop_front();
                compareLine("instLine", instLine, expLine);
                fetchCnt++;
            end else begin
                reportProtocol("instruction line returned with no fetch outstanding");
            end
        end
        if (dataRespValid && dataRespReady) begin
            if (wordExpQ.size() > 0) begin
                expWord = wordExpQ.pop_front();
                compareWord("dataRdata", dataRdata, expWord);
                readCnt++;
            end else begin
                reportProtocol("data read returned with no read outstanding");
            end
        end
        instRespReady <= ($urandom % 5) < 2;   // held low more often than not
        dataRespReady <= ($urandom % 5) < 2;
    endtask

    task automatic driveRequests();
        axiBridgePkg::instReqT ireq;
        axiBridgePkg::dataReqT dreq;
        if (instReqValid && instReqReady) begin
            instQ.push_back(instReq);
            instReqValid <= 1'b0;
        end
        if (dataReqValid && dataReqReady) begin
            dataQ.push_back(dataReq);
            dataReqValid <= 1'b0;
        end
        if ((!instReqValid || instReqReady) && issued < numReqs && ($urandom % 4) == 0) begin
            ireq.pc = (windowBase + ($urandom % 256)) & ~32'h3;
            instReq <= ireq;
            instReqValid <= 1'b1;
            issued++;
        end
        if ((!dataReqValid || dataReqReady) && issued < numReqs && ($urandom % 3) == 0) begin
            dreq.addr = (windowBase + ($urandom % 256)) & ~32'h3;
            dreq.data = $urandom;
            dreq.writeEn = ($urandom % 2) == 1;
            dreq.strobe = 4'(($urandom % 15) + 1);
            dreq.size = 3'd2;
            dataReq <= dreq;
            dataReqValid <= 1'b1;
            issued++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            checkArChannel();
            serveReadBeats();
            serveWrite();
            collectResponses();
            driveRequests();
        end
    end

    function automatic logic allDone();
        return issued >= numReqs && (fetchCnt + readCnt + writeCnt) == issued;
    endfunction

    initial begin
        seed = $urandom(76378);
        rst = 1'b1;
        instReqValid = 1'b0;
        instReq = '0;
        instRespReady = 1'b0;
        dataReqValid = 1'b0;
        dataReq = '0;
        dataRespReady = 1'b0;
        arReady = 1'b0;
        rValid = 1'b0;
        r = '0;
        awReady = 1'b0;
        wReady = 1'b0;
        bValid = 1'b0;
        bOwed = 1'b0;
        arWaitPrev = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compareFlag("instReqReady", instReqReady, 1'b1);
        compareFlag("dataReqReady", dataReqReady, 1'b1);
        compareFlag("instRespValid", instRespValid, 1'b0);
        compareFlag("dataRespValid", dataRespValid, 1'b0);
        compareFlag("arValid", arValid, 1'b0);
        compareFlag("rReady", rReady, 1'b0);
        compareFlag("awValid", awValid, 1'b0);
        compareFlag("wValid", wValid, 1'b0);
        compareFlag("bReady", bReady, 1'b0);
        cycles = 0;
        while (!allDone() && cycles < runLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (!allDone()) begin
            timeoutCnt++;
            $display("timeout: only %0d of %0d requests completed after %0d cycles",
                     fetchCnt + readCnt + writeCnt, issued, cycles);
        end else begin
            repeat (50) @(posedge clk);   // quiet tail so a stray extra response shows up
        end
        if (instQ.size() + dataQ.size() + lineExpQ.size() + wordExpQ.size() != 0)
            reportProtocol("requests were left without a response");
        $write("errors: %0d mismatch, %0d protocol, %0d timeout",
               mismatchCnt, protocolCnt, timeoutCnt);
        $display(" (%0d fetches, %0d reads, %0d writes, %0d arbitrations)",
                 fetchCnt, readCnt, writeCnt, arbCnt);
        if (mismatchCnt + protocolCnt + timeoutCnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
verilog/axiBridgePkg.sv
verilog/axiReqCapture.sv
verilog/axiReadEngine.sv
verilog/axiWriteEngine.sv
verilog/axiBridge.sv
verif/axiBridgeTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := axiBridgeTb
FILELIST  := list.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
